// ==== sim.f ====
+incdir+.
riscv_pkg.sv
ram.sv
mem_arbiter.sv
apb_port.sv
alu.sv
cpu_core.sv
riscv_top.sv
tb_riscv.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_riscv
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_ref.svh ====
// Reference RV32I subset model and program builders; regs start at zero, pc at zero.
// Images cover the first IMG_WORDS words; results live from byte 0x300 upward.
`ifndef TB_REF_SVH
`define TB_REF_SVH

localparam int IMG_WORDS = 256;
localparam int DATA_BASE = 128;
localparam int RES_BASE  = 192;
localparam int MAX_STEPS = 400;
localparam riscv_pkg::word_t EBREAK = 32'h0010_0073;

riscv_pkg::word_t img [IMG_WORDS];
riscv_pkg::word_t ref_mem [IMG_WORDS];
int emit_idx;
logic [11:0] res_off;

function automatic riscv_pkg::word_t enc_r(input logic [6:0] f7, input riscv_pkg::reg_idx_t rs2,
  input riscv_pkg::reg_idx_t rs1, input logic [2:0] f3, input riscv_pkg::reg_idx_t rd,
  input logic [6:0] op);
  return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic riscv_pkg::word_t enc_i(input logic [11:0] imm, input riscv_pkg::reg_idx_t rs1,
  input logic [2:0] f3, input riscv_pkg::reg_idx_t rd, input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic riscv_pkg::word_t enc_s(input logic [11:0] imm, input riscv_pkg::reg_idx_t rs2,
  input riscv_pkg::reg_idx_t rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], riscv_pkg::OP_STORE};
endfunction

function automatic riscv_pkg::word_t enc_b(input logic [12:0] imm, input riscv_pkg::reg_idx_t rs2,
  input riscv_pkg::reg_idx_t rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], riscv_pkg::OP_BRANCH};
endfunction

function automatic riscv_pkg::word_t enc_u(input logic [19:0] imm, input riscv_pkg::reg_idx_t rd,
  input logic [6:0] op);
  return {imm, rd, op};
endfunction

function automatic riscv_pkg::word_t enc_j(input logic [20:0] imm, input riscv_pkg::reg_idx_t rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, riscv_pkg::OP_JAL};
endfunction

function automatic riscv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
  input riscv_pkg::word_t a, input riscv_pkg::word_t b);
  case (f3)
    3'b000: return alt ? a - b : a + b;
    3'b001: return a << b[4:0];
    3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011: return (a < b) ? 32'd1 : 32'd0;
    3'b100: return a ^ b;
    3'b101:
    begin
      if (alt)
        return $signed(a) >>> b[4:0];
      return a >> b[4:0];
    end
    3'b110: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input riscv_pkg::word_t a,
  input riscv_pkg::word_t b);
  case (f3)
    3'b000: return a == b;
    3'b001: return a != b;
    3'b100: return $signed(a) < $signed(b);
    3'b101: return $signed(a) >= $signed(b);
    3'b110: return a < b;
    3'b111: return a >= b;
    default: return 1'b0;
  endcase
endfunction

// Runs ref_mem in place. Returns 1 on ebreak, 2 on an illegal opcode, 0 at the step limit.
function automatic int run_reference();
  riscv_pkg::word_t x [32];
  riscv_pkg::word_t ins;
  riscv_pkg::word_t a;
  riscv_pkg::word_t b;
  riscv_pkg::word_t imm_i;
  riscv_pkg::word_t imm_s;
  riscv_pkg::word_t ea;
  riscv_pkg::word_t ld;
  riscv_pkg::word_t pc;
  riscv_pkg::word_t nxt;
  riscv_pkg::reg_idx_t rd;
  logic [2:0] f3;
  int lane;
  for (int k = 0; k < 32; k++)
    x[k] = '0;
  pc = '0;
  for (int step = 0; step < MAX_STEPS; step++)
  begin
    ins = ref_mem[pc[9:2]];
    rd = ins[11:7];
    f3 = ins[14:12];
    a = x[ins[19:15]];
    b = x[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    nxt = pc + 32'd4;
    case (ins[6:0])
      riscv_pkg::OP_LUI: x[rd] = {ins[31:12], 12'b0};
      riscv_pkg::OP_AUIPC: x[rd] = pc + {ins[31:12], 12'b0};
      riscv_pkg::OP_JAL:
      begin
        x[rd] = pc + 32'd4;
        nxt = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      riscv_pkg::OP_JALR:
      begin
        nxt = (a + imm_i) & ~32'd1;
        x[rd] = pc + 32'd4;
      end
      riscv_pkg::OP_BRANCH:
      begin
        if (branch_ref(f3, a, b))
          nxt = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      end
      riscv_pkg::OP_LOAD:
      begin
        ea = a + imm_i;
        ld = ref_mem[ea[9:2]] >> {ea[1:0], 3'b000};
        case (f3)
          3'b000: x[rd] = {{24{ld[7]}}, ld[7:0]};
          3'b100: x[rd] = {24'b0, ld[7:0]};
          3'b001: x[rd] = {{16{ld[15]}}, ld[15:0]};
          3'b101: x[rd] = {16'b0, ld[15:0]};
          default: x[rd] = ld;
        endcase
      end
      riscv_pkg::OP_STORE:
      begin
        ea = a + imm_s;
        lane = int'(ea[1:0]);
        case (f3)
          3'b000: ref_mem[ea[9:2]][8*lane +: 8] = b[7:0];
          3'b001: ref_mem[ea[9:2]][16*(lane/2) +: 16] = b[15:0];
          default: ref_mem[ea[9:2]] = b;
        endcase
      end
      riscv_pkg::OP_ALU_IMM: x[rd] = alu_ref(f3, (f3 == 3'b101) && ins[30], a, imm_i);
      riscv_pkg::OP_ALU_REG: x[rd] = alu_ref(f3, ins[30], a, b);
      riscv_pkg::OP_SYSTEM: return 1;
      default: return 2;
    endcase
    x[0] = '0;
    pc = nxt;
  end
  return 0;
endfunction

task automatic emit(input riscv_pkg::word_t w);
  img[emit_idx] = w;
  emit_idx++;
endtask

// Stores rs to the next result slot.
task automatic emit_result(input riscv_pkg::reg_idx_t rs);
  emit(enc_s(res_off, rs, 5'd0, 3'b010));
  res_off = res_off + 12'd4;
endtask

// Zeroed image with 16 random data words at byte 0x200.
task automatic clear_img();
  riscv_pkg::word_t r;
  for (int k = 0; k < IMG_WORDS; k++)
    img[k] = '0;
  for (int k = 0; k < 16; k++)
  begin
    r = $random(seed);
    img[DATA_BASE + k] = r;
  end
  emit_idx = 0;
  res_off = 12'h300;
endtask

task automatic build_alu();
  riscv_pkg::word_t r;
  clear_img();
  emit(enc_i(12'h200, 5'd0, 3'b010, 5'd1, riscv_pkg::OP_LOAD));
  emit(enc_i(12'h204, 5'd0, 3'b010, 5'd2, riscv_pkg::OP_LOAD));
  for (int f = 0; f < 8; f++)
  begin
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'(f), 5'd3, riscv_pkg::OP_ALU_REG));
    emit_result(5'd3);
  end
  emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3, riscv_pkg::OP_ALU_REG));
  emit_result(5'd3);
  emit(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd3, riscv_pkg::OP_ALU_REG));
  emit_result(5'd3);
  // Immediate forms without shifts.
  for (int f = 0; f < 8; f++)
  begin
    if (f != 1 && f != 5)
    begin
      r = $random(seed);
      emit(enc_i(r[11:0], 5'd1, 3'(f), 5'd3, riscv_pkg::OP_ALU_IMM));
      emit_result(5'd3);
    end
  end
  r = $random(seed);
  emit(enc_i({7'h00, r[4:0]}, 5'd1, 3'b001, 5'd3, riscv_pkg::OP_ALU_IMM));
  emit_result(5'd3);
  emit(enc_i({7'h00, r[9:5]}, 5'd1, 3'b101, 5'd3, riscv_pkg::OP_ALU_IMM));
  emit_result(5'd3);
  emit(enc_i({7'h20, r[14:10]}, 5'd1, 3'b101, 5'd3, riscv_pkg::OP_ALU_IMM));
  emit_result(5'd3);
  r = $random(seed);
  emit(enc_u(r[19:0], 5'd3, riscv_pkg::OP_LUI));
  emit_result(5'd3);
  emit(enc_u(r[31:12], 5'd3, riscv_pkg::OP_AUIPC));
  emit_result(5'd3);
  emit(EBREAK);
endtask

task automatic build_ldst();
  clear_img();
  for (int k = 0; k < 4; k++)
    emit(enc_i(12'(12'h200 + 4*k), 5'd0, 3'b010, 5'(k + 1), riscv_pkg::OP_LOAD));
  for (int k = 0; k < 4; k++)
    emit(enc_s(12'(12'h300 + k), 5'(k + 1), 5'd0, 3'b000));
  emit(enc_s(12'h304, 5'd1, 5'd0, 3'b001));
  emit(enc_s(12'h306, 5'd3, 5'd0, 3'b001));
  emit(enc_s(12'h308, 5'd4, 5'd0, 3'b010));
  res_off = 12'h30c;
  for (int k = 0; k < 4; k++)
  begin
    emit(enc_i(12'(12'h200 + k), 5'd0, 3'b000, 5'd5, riscv_pkg::OP_LOAD));
    emit_result(5'd5);
    emit(enc_i(12'(12'h204 + k), 5'd0, 3'b100, 5'd5, riscv_pkg::OP_LOAD));
    emit_result(5'd5);
  end
  for (int k = 0; k < 4; k += 2)
  begin
    emit(enc_i(12'(12'h208 + k), 5'd0, 3'b001, 5'd5, riscv_pkg::OP_LOAD));
    emit_result(5'd5);
    emit(enc_i(12'(12'h20c + k), 5'd0, 3'b101, 5'd5, riscv_pkg::OP_LOAD));
    emit_result(5'd5);
  end
  // Read back what was just stored.
  emit(enc_i(12'h300, 5'd0, 3'b010, 5'd5, riscv_pkg::OP_LOAD));
  emit_result(5'd5);
  emit(enc_i(12'h303, 5'd0, 3'b000, 5'd5, riscv_pkg::OP_LOAD));
  emit_result(5'd5);
  emit(enc_i(12'h306, 5'd0, 3'b101, 5'd5, riscv_pkg::OP_LOAD));
  emit_result(5'd5);
  emit(EBREAK);
endtask

task automatic build_ctrl();
  int loop_idx;
  int start;
  int limit;
  logic [2:0] f3;
  logic swap;
  clear_img();
  // beq exits forward out of a jal loop.
  emit(enc_i(12'h000, 5'd0, 3'b000, 5'd2, riscv_pkg::OP_ALU_IMM));
  emit(enc_i(12'h003, 5'd0, 3'b000, 5'd3, riscv_pkg::OP_ALU_IMM));
  loop_idx = emit_idx;
  emit(enc_i(12'h001, 5'd2, 3'b000, 5'd2, riscv_pkg::OP_ALU_IMM));
  emit(enc_b(13'd8, 5'd3, 5'd2, 3'b000));
  emit(enc_j(21'((loop_idx - emit_idx) * 4), 5'd0));
  emit_result(5'd2);
  for (int k = 1; k < 6; k++)
  begin
    case (k)
      1: {f3, start, limit, swap} = {3'b001, -32'sd3, 32'sd4, 1'b0};
      2: {f3, start, limit, swap} = {3'b100, -32'sd6, 32'sd1, 1'b0};
      3: {f3, start, limit, swap} = {3'b101, 32'sd0, 32'sd3, 1'b1};
      4: {f3, start, limit, swap} = {3'b110, 32'sd0, 32'sd5, 1'b0};
      default: {f3, start, limit, swap} = {3'b111, 32'sd1, 32'sd4, 1'b1};
    endcase
    emit(enc_i(12'(start), 5'd0, 3'b000, 5'd2, riscv_pkg::OP_ALU_IMM));
    emit(enc_i(12'(limit), 5'd0, 3'b000, 5'd3, riscv_pkg::OP_ALU_IMM));
    loop_idx = emit_idx;
    emit(enc_i(12'h001, 5'd2, 3'b000, 5'd2, riscv_pkg::OP_ALU_IMM));
    if (swap)
      emit(enc_b(13'((loop_idx - emit_idx) * 4), 5'd2, 5'd3, f3));
    else
      emit(enc_b(13'((loop_idx - emit_idx) * 4), 5'd3, 5'd2, f3));
    emit_result(5'd2);
  end
  // Call and return that store both link registers.
  emit(enc_j(21'd20, 5'd1));
  emit_result(5'd1);
  emit_result(5'd5);
  emit_result(5'd10);
  emit(EBREAK);
  emit(enc_i(12'h055, 5'd0, 3'b000, 5'd10, riscv_pkg::OP_ALU_IMM));
  emit(enc_i(12'h000, 5'd1, 3'b000, 5'd5, riscv_pkg::OP_JALR));
endtask

task automatic build_fault();
  clear_img();
  emit(enc_i(12'h123, 5'd0, 3'b000, 5'd1, riscv_pkg::OP_ALU_IMM));
  emit_result(5'd1);
  emit(enc_i(12'h001, 5'd1, 3'b000, 5'd1, riscv_pkg::OP_ALU_IMM));
  emit_result(5'd1);
  emit(32'h0000_007f);
  emit(enc_i(12'h001, 5'd1, 3'b000, 5'd1, riscv_pkg::OP_ALU_IMM));
  emit_result(5'd1);
  emit(EBREAK);
endtask

`endif

// ==== tb_riscv.sv ====
// Drives riscv_top over APB and compares results with the reference model in tb_ref.svh.
// Each program run starts from reset; RAM outside the loaded image is left as it was.
module tb_riscv;

  localparam int MAX_CYCLES = 20000;

  logic raw_clk;
  logic button_reset;
  logic button_halt;
  riscv_pkg::apb_req_t apb_req;
  riscv_pkg::apb_rsp_t apb_rsp;
  logic halted;
  logic fault;

  integer seed;
  int cycles;
  int checks;
  int word_errs;
  int flag_errs;
  int misc_errs;

  `include "tb_ref.svh"

  riscv_top #(
    .MEM_WORDS (1024),
    .RESET_PC  (16'h0000)
  ) dut0 (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .button_halt  (button_halt),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .halted       (halted),
    .fault        (fault)
  );

  always #2 raw_clk = ~raw_clk;

  // Run limit.
  always @(posedge raw_clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_word(input string name, input riscv_pkg::word_t exp,
    input riscv_pkg::word_t act);
    checks++;
    if (exp !== act)
    begin
      word_errs++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act)
    begin
      flag_errs++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  // One APB transfer: setup, access, then wait for pready.
  task automatic apb_xfer(input logic wr, input riscv_pkg::addr_t addr,
    input riscv_pkg::word_t wdata, output riscv_pkg::word_t rdata, output logic err);
    @(negedge raw_clk);
    apb_req.psel = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite = wr;
    apb_req.paddr = addr;
    apb_req.pwdata = wdata;
    @(negedge raw_clk);
    apb_req.penable = 1'b1;
    do
      @(negedge raw_clk);
    while (!apb_rsp.pready);
    rdata = apb_rsp.prdata;
    err = apb_rsp.pslverr;
    apb_req.psel = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_write(input riscv_pkg::addr_t addr, input riscv_pkg::word_t data);
    riscv_pkg::word_t d;
    logic err;
    apb_xfer(1'b1, addr, data, d, err);
    check_flag("pslverr", 1'b0, err);
  endtask

  task automatic apb_read(input riscv_pkg::addr_t addr, output riscv_pkg::word_t data);
    logic err;
    apb_xfer(1'b0, addr, '0, data, err);
    check_flag("pslverr", 1'b0, err);
  endtask

  task automatic test_apb_path();
    riscv_pkg::word_t expect_mem [1024];
    logic seen [1024];
    riscv_pkg::word_t r;
    riscv_pkg::word_t d;
    riscv_pkg::addr_t a;
    riscv_pkg::addr_t probe;
    logic err;
    for (int k = 0; k < 1024; k++)
      seen[k] = 1'b0;
    for (int n = 0; n < 64; n++)
    begin
      r = $random(seed);
      a = {4'b0000, r[9:0], 2'b00};
      r = $random(seed);
      apb_write(a, r);
      expect_mem[a[11:2]] = r;
      seen[a[11:2]] = 1'b1;
      probe = a;
    end
    for (int k = 0; k < 1024; k++)
    begin
      if (seen[k])
      begin
        apb_read(16'(k * 4), d);
        check_word($sformatf("prdata[%h]", 16'(k * 4)), expect_mem[k], d);
      end
    end
    // Misaligned and out-of-range writes must be refused.
    apb_xfer(1'b1, probe | 16'h0002, ~expect_mem[probe[11:2]], d, err);
    check_flag("pslverr", 1'b1, err);
    apb_xfer(1'b1, probe + 16'h1000, ~expect_mem[probe[11:2]], d, err);
    check_flag("pslverr", 1'b1, err);
    apb_xfer(1'b0, 16'hfffc, '0, d, err);
    check_flag("pslverr", 1'b1, err);
    apb_read(probe, d);
    check_word("prdata", expect_mem[probe[11:2]], d);
  endtask

  task automatic reset_system();
    @(negedge raw_clk);
    button_reset = 1'b0;
    button_halt = 1'b0;
    apb_req = '0;
    repeat (4) @(negedge raw_clk);
    button_reset = 1'b1;
  endtask

  // Load img, run it on the core and on the reference, compare the result region.
  task automatic run_image(input logic with_traffic);
    int reason;
    int n;
    riscv_pkg::word_t d;
    reset_system();
    for (int k = 0; k < IMG_WORDS; k++)
      apb_write(16'(k * 4), img[k]);
    ref_mem = img;
    reason = run_reference();
    if (reason == 0)
    begin
      misc_errs++;
      $display("Reference model did not reach a stop within %0d steps", MAX_STEPS);
    end
    @(negedge raw_clk);
    button_halt = 1'b1;
    if (with_traffic)
    begin
      n = 0;
      while (n < 16 || !(halted || fault))
      begin
        apb_read(16'(16'h0200 + 4 * (n % 16)), d);
        check_word("prdata", img[DATA_BASE + n % 16], d);
        n++;
      end
    end
    while (!(halted || fault))
      @(negedge raw_clk);
    check_flag("halted", reason == 1, halted);
    check_flag("fault", reason == 2, fault);
    for (int k = RES_BASE; k < IMG_WORDS; k++)
    begin
      apb_read(16'(k * 4), d);
      check_word($sformatf("mem[%h]", 16'(k * 4)), ref_mem[k], d);
    end
  endtask

  initial
  begin
    raw_clk = 1'b0;
    button_reset = 1'b0;
    button_halt = 1'b0;
    apb_req = '0;
    seed = 32'h9a8b;
    cycles = 0;
    checks = 0;
    word_errs = 0;
    flag_errs = 0;
    misc_errs = 0;
    reset_system();
    test_apb_path();
    build_alu();
    run_image(1'b0);
    build_ldst();
    run_image(1'b0);
    build_ctrl();
    run_image(1'b0);
    build_fault();
    run_image(1'b0);
    // Same load/store program, now under APB contention.
    build_ldst();
    run_image(1'b1);
    $display("Checks %0d, value errors %0d, flag errors %0d, other errors %0d",
             checks, word_errs, flag_errs, misc_errs);
    if (word_errs + flag_errs + misc_errs == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== riscv_top.sv ====
// Core and APB port share one RAM; the APB port wins every conflict.
module riscv_top #(
  parameter int               MEM_WORDS = 1024,
  parameter riscv_pkg::addr_t RESET_PC  = '0
) (
  input  logic                raw_clk,
  input  logic                button_reset,
  input  logic                button_halt,
  input  riscv_pkg::apb_req_t apb_req,
  output riscv_pkg::apb_rsp_t apb_rsp,
  output logic                halted,
  output logic                fault
);

  riscv_pkg::mem_req_t cpu_mem_req;
  riscv_pkg::mem_rsp_t cpu_mem_rsp;
  riscv_pkg::mem_req_t apb_mem_req;
  riscv_pkg::mem_rsp_t apb_mem_rsp;
  riscv_pkg::mem_req_t ram_req;
  riscv_pkg::mem_rsp_t ram_rsp;

  cpu_core #(.RESET_PC(RESET_PC)) cpu_core_0 (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .button_halt  (button_halt),
    .mem_req      (cpu_mem_req),
    .mem_rsp      (cpu_mem_rsp),
    .halted       (halted),
    .fault        (fault)
  );

  apb_port #(.MEM_WORDS(MEM_WORDS)) apb_port_0 (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .mem_req      (apb_mem_req),
    .mem_rsp      (apb_mem_rsp)
  );

  mem_arbiter mem_arbiter_0 (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .apb_req      (apb_mem_req),
    .apb_rsp      (apb_mem_rsp),
    .cpu_req      (cpu_mem_req),
    .cpu_rsp      (cpu_mem_rsp),
    .ram_req      (ram_req),
    .ram_rsp      (ram_rsp)
  );

  ram #(.MEM_WORDS(MEM_WORDS)) ram_0 (
    .raw_clk (raw_clk),
    .req     (ram_req),
    .rsp     (ram_rsp)
  );

endmodule

// ==== cpu_core.sv ====
// Multi-cycle RV32I subset; misaligned halves are not supported and any SYSTEM op halts.
// Holding button_halt low keeps the core idle, or stops it at the next instruction.
module cpu_core #(
  parameter riscv_pkg::addr_t RESET_PC = '0
) (
  input  logic                raw_clk,
  input  logic                button_reset,
  input  logic                button_halt,
  output riscv_pkg::mem_req_t mem_req,
  input  riscv_pkg::mem_rsp_t mem_rsp,
  output logic                halted,
  output logic                fault
);

  typedef enum logic [2:0] {
    S_IDLE, S_FETCH, S_DECODE, S_EXECUTE, S_MEMORY, S_HALTED, S_FAULT
  } state_e;

  state_e state_q;
  state_e next_fetch;
  riscv_pkg::addr_t pc_q;
  riscv_pkg::addr_t pc_plus4;
  riscv_pkg::addr_t ea_q;
  riscv_pkg::instr_u ir_q;
  riscv_pkg::word_t regs [32];
  riscv_pkg::word_t rs1_q;
  riscv_pkg::word_t rs2_q;
  riscv_pkg::word_t imm;
  riscv_pkg::word_t imm_q;
  riscv_pkg::word_t alu_a;
  riscv_pkg::word_t alu_b;
  riscv_pkg::word_t alu_result;
  riscv_pkg::word_t st_data;
  riscv_pkg::word_t ld_shift;
  riscv_pkg::word_t ld_data;
  riscv_pkg::word_t rf_wdata;
  riscv_pkg::strb_t st_strb;
  riscv_pkg::reg_idx_t rd;
  riscv_pkg::alu_op_e alu_op;
  logic [6:0] opcode;
  logic sub_sra;
  logic take_branch;
  logic rf_we;

  assign opcode = ir_q.r.opcode;
  assign rd = ir_q.r.rd;
  assign pc_plus4 = pc_q + 16'd4;
  assign next_fetch = button_halt ? S_FETCH : S_HALTED;
  assign halted = (state_q == S_HALTED);
  assign fault = (state_q == S_FAULT);

  // Immediate by format.
  always_comb
  begin
    case (opcode)
      riscv_pkg::OP_LUI, riscv_pkg::OP_AUIPC: imm = {ir_q.u.imm, 12'b0};
      riscv_pkg::OP_JAL:
        imm = {{12{ir_q.j.imm20}}, ir_q.j.imm19_12, ir_q.j.imm11, ir_q.j.imm10_1, 1'b0};
      riscv_pkg::OP_BRANCH:
        imm = {{20{ir_q.b.imm12}}, ir_q.b.imm11, ir_q.b.imm10_5, ir_q.b.imm4_1, 1'b0};
      riscv_pkg::OP_STORE: imm = {{20{ir_q.s.imm_hi[6]}}, ir_q.s.imm_hi, ir_q.s.imm_lo};
      default: imm = {{20{ir_q.i.imm[11]}}, ir_q.i.imm};
    endcase
  end

  // Bit 30 selects sub only in the register group, sra in both groups.
  assign sub_sra = ir_q.r.funct7[5] && ((ir_q.r.funct3 == 3'b101) ||
                   (ir_q.r.funct3 == 3'b000 && opcode == riscv_pkg::OP_ALU_REG));

  always_comb
  begin
    alu_a = rs1_q;
    alu_b = imm_q;
    alu_op = riscv_pkg::ALU_ADD;
    case (opcode)
      riscv_pkg::OP_ALU_REG:
      begin
        alu_b = rs2_q;
        alu_op = riscv_pkg::alu_op_e'({sub_sra, ir_q.r.funct3});
      end
      riscv_pkg::OP_ALU_IMM: alu_op = riscv_pkg::alu_op_e'({sub_sra, ir_q.r.funct3});
      riscv_pkg::OP_BRANCH: alu_b = rs2_q;
      riscv_pkg::OP_LUI: alu_a = '0;
      riscv_pkg::OP_AUIPC, riscv_pkg::OP_JAL: alu_a = 32'(pc_q);
      default: ;
    endcase
  end

  alu alu_0 (
    .op          (alu_op),
    .a           (alu_a),
    .b           (alu_b),
    .funct3      (ir_q.b.funct3),
    .result      (alu_result),
    .take_branch (take_branch)
  );

  // Store lanes are replicated; strobes pick the addressed bytes.
  always_comb
  begin
    st_data = rs2_q;
    st_strb = 4'b1111;
    case (ir_q.s.funct3[1:0])
      2'b00:
      begin
        st_data = {4{rs2_q[7:0]}};
        st_strb = 4'b0001 << ea_q[1:0];
      end
      2'b01:
      begin
        st_data = {2{rs2_q[15:0]}};
        st_strb = 4'b0011 << {ea_q[1], 1'b0};
      end
      default: ;
    endcase
  end

  always_comb
  begin
    ld_shift = mem_rsp.rdata >> {ea_q[1:0], 3'b000};
    case (ir_q.i.funct3)
      3'b000:  ld_data = {{24{ld_shift[7]}}, ld_shift[7:0]};
      3'b100:  ld_data = {24'b0, ld_shift[7:0]};
      3'b001:  ld_data = {{16{ld_shift[15]}}, ld_shift[15:0]};
      3'b101:  ld_data = {16'b0, ld_shift[15:0]};
      default: ld_data = mem_rsp.rdata;
    endcase
  end

  // Valid drops in the response cycle, which gives the gap between requests.
  always_comb
  begin
    mem_req.valid = ((state_q == S_FETCH) || (state_q == S_MEMORY)) && !mem_rsp.valid;
    mem_req.write = (state_q == S_MEMORY) && (opcode == riscv_pkg::OP_STORE);
    mem_req.addr  = (state_q == S_MEMORY) ? {ea_q[riscv_pkg::ADDR_W-1:2], 2'b00} : pc_q;
    mem_req.wdata = st_data;
    mem_req.strb  = (state_q == S_MEMORY) ? st_strb : 4'b1111;
  end

  always_comb
  begin
    rf_we = 1'b0;
    rf_wdata = alu_result;
    if (state_q == S_EXECUTE)
    begin
      case (opcode)
        riscv_pkg::OP_LUI, riscv_pkg::OP_AUIPC, riscv_pkg::OP_ALU_IMM, riscv_pkg::OP_ALU_REG:
          rf_we = 1'b1;
        riscv_pkg::OP_JAL, riscv_pkg::OP_JALR:
        begin
          rf_we = 1'b1;
          rf_wdata = 32'(pc_plus4);
        end
        default: ;
      endcase
    end
    else if (state_q == S_MEMORY && opcode == riscv_pkg::OP_LOAD && mem_rsp.valid)
    begin
      rf_we = 1'b1;
      rf_wdata = ld_data;
    end
  end

  always_ff @(posedge raw_clk)
  begin
    if (rf_we && (rd != '0))
      regs[rd] <= rf_wdata;
  end

  always_ff @(posedge raw_clk)
  begin
    if (state_q == S_FETCH && mem_rsp.valid)
      ir_q <= mem_rsp.rdata;
    if (state_q == S_DECODE)
    begin
      // x0 always reads zero.
      rs1_q <= (ir_q.r.rs1 == '0) ? '0 : regs[ir_q.r.rs1];
      rs2_q <= (ir_q.r.rs2 == '0) ? '0 : regs[ir_q.r.rs2];
      imm_q <= imm;
    end
    if (state_q == S_EXECUTE)
      ea_q <= alu_result[riscv_pkg::ADDR_W-1:0];
  end

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state_q <= S_IDLE;
      pc_q <= RESET_PC;
    end
    else
    begin
      case (state_q)
        S_IDLE: if (button_halt) state_q <= S_FETCH;
        S_FETCH: if (mem_rsp.valid) state_q <= S_DECODE;
        S_DECODE:
        begin
          case (opcode)
            riscv_pkg::OP_LUI, riscv_pkg::OP_AUIPC, riscv_pkg::OP_JAL, riscv_pkg::OP_JALR,
            riscv_pkg::OP_BRANCH, riscv_pkg::OP_LOAD, riscv_pkg::OP_STORE,
            riscv_pkg::OP_ALU_IMM, riscv_pkg::OP_ALU_REG: state_q <= S_EXECUTE;
            riscv_pkg::OP_SYSTEM: state_q <= S_HALTED;
            default: state_q <= S_FAULT;
          endcase
        end
        S_EXECUTE:
        begin
          case (opcode)
            riscv_pkg::OP_JAL: pc_q <= alu_result[riscv_pkg::ADDR_W-1:0];
            riscv_pkg::OP_JALR: pc_q <= {alu_result[riscv_pkg::ADDR_W-1:1], 1'b0};
            riscv_pkg::OP_BRANCH: pc_q <= take_branch ? pc_q + imm_q[15:0] : pc_plus4;
            default: pc_q <= pc_plus4;
          endcase
          if (opcode == riscv_pkg::OP_LOAD || opcode == riscv_pkg::OP_STORE)
            state_q <= S_MEMORY;
          else
            state_q <= next_fetch;
        end
        S_MEMORY: if (mem_rsp.valid) state_q <= next_fetch;
        default: state_q <= state_q;
      endcase
    end
  end

  a_fetch_aligned: assert property (@(posedge raw_clk) disable iff (!button_reset)
    (mem_req.valid && state_q == S_FETCH) |-> (mem_req.addr[1:0] == 2'b00));

endmodule

// ==== alu.sv ====
// Purely combinational; shifts use b[4:0], funct3 is only used for branches.
module alu (
  input  riscv_pkg::alu_op_e op,
  input  riscv_pkg::word_t   a,
  input  riscv_pkg::word_t   b,
  input  logic [2:0]         funct3,
  output riscv_pkg::word_t   result,
  output logic               take_branch
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb
  begin
    case (op)
      riscv_pkg::ALU_ADD:  result = a + b;
      riscv_pkg::ALU_SUB:  result = a - b;
      riscv_pkg::ALU_SLL:  result = a << shamt;
      riscv_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
      riscv_pkg::ALU_SLTU: result = {31'b0, a < b};
      riscv_pkg::ALU_XOR:  result = a ^ b;
      riscv_pkg::ALU_SRL:  result = a >> shamt;
      riscv_pkg::ALU_SRA:  result = $signed(a) >>> shamt;
      riscv_pkg::ALU_OR:   result = a | b;
      riscv_pkg::ALU_AND:  result = a & b;
      default:             result = a + b;
    endcase
  end

  // Branch conditions, beq through bgeu.
  always_comb
  begin
    case (funct3)
      3'b000:  take_branch = (a == b);
      3'b001:  take_branch = (a != b);
      3'b100:  take_branch = ($signed(a) < $signed(b));
      3'b101:  take_branch = ($signed(a) >= $signed(b));
      3'b110:  take_branch = (a < b);
      3'b111:  take_branch = (a >= b);
      default: take_branch = 1'b0;
    endcase
  end

endmodule

// ==== apb_port.sv ====
// Whole-word transfers only; misaligned or out-of-range addresses end with pslverr.
module apb_port #(
  parameter int MEM_WORDS = 1024
) (
  input  logic                raw_clk,
  input  logic                button_reset,
  input  riscv_pkg::apb_req_t apb_req,
  output riscv_pkg::apb_rsp_t apb_rsp,
  output riscv_pkg::mem_req_t mem_req,
  input  riscv_pkg::mem_rsp_t mem_rsp
);

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_RESP} state_e;

  state_e state_q;
  logic addr_ok;
  logic err_q;
  riscv_pkg::word_t rdata_q;

  assign addr_ok = (apb_req.paddr[1:0] == 2'b00) &&
                   (32'(apb_req.paddr[riscv_pkg::ADDR_W-1:2]) < MEM_WORDS);

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state_q <= S_IDLE;
      err_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        S_IDLE:
        begin
          // Access phase starts the transfer.
          if (apb_req.psel && apb_req.penable)
          begin
            err_q <= !addr_ok;
            state_q <= addr_ok ? S_REQ : S_RESP;
          end
        end
        S_REQ: if (mem_rsp.valid) state_q <= S_RESP;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge raw_clk)
  begin
    if (state_q == S_REQ && mem_rsp.valid)
      rdata_q <= mem_rsp.rdata;
  end

  // Master holds its fields until pready, so they feed the request directly.
  always_comb
  begin
    mem_req.valid = (state_q == S_REQ);
    mem_req.write = apb_req.pwrite;
    mem_req.addr  = apb_req.paddr;
    mem_req.wdata = apb_req.pwdata;
    mem_req.strb  = '1;
  end

  always_comb
  begin
    apb_rsp.pready  = (state_q == S_RESP);
    apb_rsp.pslverr = (state_q == S_RESP) && err_q;
    apb_rsp.prdata  = err_q ? '0 : rdata_q;
  end

  a_paddr_stable: assert property (@(posedge raw_clk) disable iff (!button_reset)
    (apb_req.psel && apb_req.penable && !apb_rsp.pready) |=> $stable(apb_req.paddr));

endmodule

// ==== mem_arbiter.sv ====
// APB side always wins; a requester with a response in flight is not granted again.
module mem_arbiter (
  input  logic                raw_clk,
  input  logic                button_reset,
  input  riscv_pkg::mem_req_t apb_req,
  output riscv_pkg::mem_rsp_t apb_rsp,
  input  riscv_pkg::mem_req_t cpu_req,
  output riscv_pkg::mem_rsp_t cpu_rsp,
  output riscv_pkg::mem_req_t ram_req,
  input  riscv_pkg::mem_rsp_t ram_rsp
);

  logic apb_gnt;
  logic cpu_gnt;
  logic apb_pend_q;
  logic cpu_pend_q;

  // Fixed priority that skips a side whose response is due this cycle.
  assign apb_gnt = apb_req.valid && !apb_pend_q;
  assign cpu_gnt = cpu_req.valid && !cpu_pend_q && !apb_gnt;

  always_comb
  begin
    ram_req = apb_gnt ? apb_req : cpu_req;
    ram_req.valid = apb_gnt || cpu_gnt;
  end

  // Winner of the last cycle owns the RAM response.
  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      apb_pend_q <= 1'b0;
      cpu_pend_q <= 1'b0;
    end
    else
    begin
      apb_pend_q <= apb_gnt;
      cpu_pend_q <= cpu_gnt;
    end
  end

  always_comb
  begin
    apb_rsp.valid = ram_rsp.valid && apb_pend_q;
    apb_rsp.rdata = ram_rsp.rdata;
    cpu_rsp.valid = ram_rsp.valid && cpu_pend_q;
    cpu_rsp.rdata = ram_rsp.rdata;
  end

  // Every RAM response follows a grant, and every grant gets its response.
  a_rsp_has_grant: assert property (@(posedge raw_clk) disable iff (!button_reset)
    ram_rsp.valid |-> (apb_pend_q || cpu_pend_q));
  a_grant_answered: assert property (@(posedge raw_clk) disable iff (!button_reset)
    (apb_pend_q || cpu_pend_q) |-> ram_rsp.valid);

endmodule

// ==== ram.sv ====
// Word RAM with byte enables; reads return the old word when read and write collide.
// Only the low address bits are decoded, so requests must stay inside MEM_WORDS.
module ram #(
  parameter int MEM_WORDS = 1024
) (
  input  logic                raw_clk,
  input  riscv_pkg::mem_req_t req,
  output riscv_pkg::mem_rsp_t rsp
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  riscv_pkg::word_t mem [MEM_WORDS];
  logic [IDX_W-1:0] idx;

  assign idx = req.addr[IDX_W+1:2];

  always_ff @(posedge raw_clk)
  begin
    if (req.valid && req.write)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (req.strb[b])
          mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
      end
    end
    rsp.rdata <= mem[idx];
    rsp.valid <= req.valid;
  end

  a_addr_in_range: assert property (@(posedge raw_clk)
    req.valid |-> (32'(req.addr[riscv_pkg::ADDR_W-1:2]) < MEM_WORDS));

endmodule

// ==== riscv_pkg.sv ====
// Addresses on the memory bus are byte addresses; the RAM decodes only the low bits.
// Instruction formats follow the RV32I base encoding.
package riscv_pkg;

  localparam int ADDR_W = 16;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0] strb_t;
  typedef logic [4:0] reg_idx_t;

  // Major opcodes of the supported subset.
  localparam logic [6:0] OP_LUI     = 7'b0110111;
  localparam logic [6:0] OP_AUIPC   = 7'b0010111;
  localparam logic [6:0] OP_JAL     = 7'b1101111;
  localparam logic [6:0] OP_JALR    = 7'b1100111;
  localparam logic [6:0] OP_BRANCH  = 7'b1100011;
  localparam logic [6:0] OP_LOAD    = 7'b0000011;
  localparam logic [6:0] OP_STORE   = 7'b0100011;
  localparam logic [6:0] OP_ALU_IMM = 7'b0010011;
  localparam logic [6:0] OP_ALU_REG = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM  = 7'b1110011;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } j_type_t;

  // One instruction word seen through each format.
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } instr_u;

  // Encoded as {funct7[5], funct3} of the register group.
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    word_t wdata;
    strb_t strb;
  } mem_req_t;

  typedef struct packed {
    logic  valid;
    word_t rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    word_t pwdata;
  } apb_req_t;

  typedef struct packed {
    logic  pready;
    word_t prdata;
    logic  pslverr;
  } apb_rsp_t;

endpackage
